// ==== Bender.yml ====
package:
  name: rthunder_shared_bus

sources:
  - logic/rthunder_pkg.sv
  - logic/rthunder_bus_if.sv
  - logic/cpu_addr_decoder.sv
  - logic/shared_bus_arbiter.sv
  - logic/shared_word_ram.sv
  - logic/cpu_slot_timer.sv
  - logic/rthunder_shared_bus.sv
  - target: test
    files:
      - verification/rthunder_shared_bus_assertions.sv
      - verification/rthunder_shared_bus_tb.sv

// ==== logic/cpu_addr_decoder.sv ====
module cpu_addr_decoder import rthunder_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    cpu_port_if.decoder cpu
);

    logic       vma_q;  // qualifier for the selects.
    logic [2:0] region; // address bits 15..13.
    logic       sel;    // address bit 12.

    assign region = cpu.addr.f.region;
    assign sel    = cpu.addr.f.sel;

    //////////////////////////////
    // vma capture
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            vma_q <= 1'b0; // no selects out of reset.
        end else begin
            vma_q <= cpu.vma; // settles long before the owner slot.
        end
    end

    //////////////////////////////
    // region decode
    //////////////////////////////

    always_comb begin
        cpu.scr0_cs   = 1'b0;
        cpu.scr1_cs   = 1'b0;
        cpu.oram_cs   = 1'b0;
        cpu.mbank_cs  = 1'b0;
        cpu.sbank_cs  = 1'b0;
        cpu.latch0_cs = 1'b0;
        cpu.latch1_cs = 1'b0;
        cpu.rom_cs    = 1'b0;
        if (vma_q) begin
            case (region)
                reg_scr0:  cpu.scr0_cs = 1'b1;
                reg_scr1:  cpu.scr1_cs = 1'b1;
                reg_oram:  cpu.oram_cs = 1'b1;
                reg_bank: begin
                    cpu.mbank_cs = ~sel; // 0x6000 half.
                    cpu.sbank_cs = sel;  // 0x7000 half.
                end
                reg_latch: begin
                    cpu.latch0_cs = ~sel; // 0x8000 half.
                    cpu.latch1_cs = sel;  // 0x9000 half.
                end
                default:   cpu.rom_cs = 1'b1; // codes 5 to 7.
            endcase
        end
    end

endmodule

// ==== logic/cpu_slot_timer.sv ====
module cpu_slot_timer #(
    parameter int DIV = 4 // cycles per slot.
) (
    input  logic clk,
    input  logic rst,
    output logic cen_main,
    output logic cen_sub
);

    localparam int CW = (DIV > 1) ? $clog2(DIV) : 1;

    logic [CW-1:0] cnt;   // position inside the slot.
    logic          phase; // 0 main next. 1 sub next.

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt      <= '0;
            phase    <= 1'b0;
            cen_main <= 1'b0;
            cen_sub  <= 1'b0;
        end else if (cnt == CW'(DIV - 1)) begin
            cnt      <= '0;      // wrap.
            phase    <= ~phase;  // alternate owners.
            cen_main <= ~phase;
            cen_sub  <= phase;
        end else begin
            cnt      <= cnt + 1'b1;
            cen_main <= 1'b0;    // single cycle pulses.
            cen_sub  <= 1'b0;
        end
    end

endmodule

// ==== logic/rthunder_bus_if.sv ====
// one cpu's view of the shared bus.
interface cpu_port_if import rthunder_pkg::*; ();

    cpu_addr_u   addr;      // cpu address.
    logic [7:0]  dout;      // cpu write data.
    logic        rnw;       // high on read.
    logic        vma;       // valid memory address.

    logic        scr0_cs;   // scroll ram 0.
    logic        scr1_cs;   // scroll ram 1.
    logic        oram_cs;   // object ram.
    logic        mbank_cs;  // main bank register.
    logic        sbank_cs;  // sub bank register.
    logic        latch0_cs; // latch strobe 0.
    logic        latch1_cs; // latch strobe 1.
    logic        rom_cs;    // external rom.

    modport decoder (
        input  addr, vma,
        output scr0_cs, scr1_cs, oram_cs, mbank_cs, sbank_cs,
        output latch0_cs, latch1_cs, rom_cs
    );

    modport arbiter (
        input  addr, dout, rnw, vma,
        input  scr0_cs, scr1_cs, oram_cs, mbank_cs, sbank_cs,
        input  latch0_cs, latch1_cs, rom_cs
    );

endinterface

// 16-bit ram port with byte lanes.
interface word_ram_if import rthunder_pkg::*; ();

    logic [BUS_AW-2:0] addr;  // word address.
    logic [7:0]        wdata; // same byte on both lanes.
    logic [1:0]        we;    // bit 1 high lane. bit 0 low lane.
    logic [15:0]       rdata; // async word read.

    modport master (output addr, wdata, we, input rdata);
    modport slave  (input addr, wdata, we, output rdata);

endinterface

// ==== logic/rthunder_pkg.sv ====
package rthunder_pkg;

    //////////////////////////////
    // bus geometry
    //////////////////////////////

    localparam int BUS_AW    = 13;   // byte address bits on the shared bus.
    localparam int RAM_WORDS = 4096; // default depth of each video ram.

    //////////////////////////////
    // address regions
    //////////////////////////////

    // taken straight from cpu address bits 15..13.
    typedef enum logic [2:0] {
        reg_scr0  = 3'd0, // 0x0000 to 0x1fff.
        reg_scr1  = 3'd1, // 0x2000 to 0x3fff.
        reg_oram  = 3'd2, // 0x4000 to 0x5fff.
        reg_bank  = 3'd3, // 0x6000 to 0x7fff.
        reg_latch = 3'd4, // 0x8000 to 0x9fff.
        reg_rom   = 3'd5  // first rom code. 6 and 7 are rom too.
    } region_e;

    //////////////////////////////
    // cpu address word
    //////////////////////////////

    // one 16-bit word seen as raw bits or as split fields.
    typedef union packed {
        logic [15:0] raw;          // full cpu address.
        struct packed {
            logic [2:0]  region;   // compared against region_e.
            logic        sel;      // bit 12 picks bank or latch.
            logic [11:0] offset;   // byte offset inside the half region.
        } f;
    } cpu_addr_u;

endpackage

// ==== logic/rthunder_shared_bus.sv ====
module rthunder_shared_bus import rthunder_pkg::*; #(
    parameter int DIV   = 4,        // slot length in cycles.
    parameter int WORDS = RAM_WORDS // ram depth.
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] maddr,
    input  logic [15:0] saddr,
    input  logic [7:0]  mdout,
    input  logic [7:0]  sdout,
    input  logic        mrnw,
    input  logic        srnw,
    input  logic        mvma,
    input  logic        svma,
    input  logic [7:0]  mrom_data,
    input  logic [7:0]  srom_data,
    output logic        cen_main,
    output logic        cen_sub,
    output logic [1:0]  mbank,
    output logic [1:0]  sbank,
    output logic        latch0,
    output logic        latch1,
    output logic [7:0]  mdin,
    output logic [7:0]  sdin
);

    //////////////////////////////
    // bus interfaces
    //////////////////////////////

    cpu_port_if main_if ();  // main cpu port.
    cpu_port_if sub_if ();   // sub cpu port.
    word_ram_if scr0_if ();
    word_ram_if scr1_if ();
    word_ram_if oram_if ();

    assign main_if.addr = maddr;
    assign main_if.dout = mdout;
    assign main_if.rnw  = mrnw;
    assign main_if.vma  = mvma;
    assign sub_if.addr  = saddr;
    assign sub_if.dout  = sdout;
    assign sub_if.rnw   = srnw;
    assign sub_if.vma   = svma;

    //////////////////////////////
    // blocks
    //////////////////////////////

    cpu_slot_timer #(.DIV(DIV)) slot_timer_inst (
        .clk      (clk),
        .rst      (rst),
        .cen_main (cen_main),
        .cen_sub  (cen_sub)
    );

    cpu_addr_decoder main_decoder_inst (.clk(clk), .rst(rst), .cpu(main_if));
    cpu_addr_decoder sub_decoder_inst  (.clk(clk), .rst(rst), .cpu(sub_if));

    shared_bus_arbiter arbiter_inst (
        .clk       (clk),
        .rst       (rst),
        .cen_main  (cen_main),
        .cen_sub   (cen_sub),
        .main_cpu  (main_if),
        .sub_cpu   (sub_if),
        .scr0      (scr0_if),
        .scr1      (scr1_if),
        .oram      (oram_if),
        .mrom_data (mrom_data),
        .srom_data (srom_data),
        .mbank     (mbank),
        .sbank     (sbank),
        .latch0    (latch0),
        .latch1    (latch1),
        .mdin      (mdin),
        .sdin      (sdin)
    );

    shared_word_ram #(.WORDS(WORDS)) scr0_ram_inst (.clk(clk), .mem(scr0_if));
    shared_word_ram #(.WORDS(WORDS)) scr1_ram_inst (.clk(clk), .mem(scr1_if));
    shared_word_ram #(.WORDS(WORDS)) oram_ram_inst (.clk(clk), .mem(oram_if));

endmodule

// ==== logic/shared_bus_arbiter.sv ====
module shared_bus_arbiter import rthunder_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen_main,
    input  logic        cen_sub,
    cpu_port_if.arbiter main_cpu,
    cpu_port_if.arbiter sub_cpu,
    word_ram_if.master  scr0,
    word_ram_if.master  scr1,
    word_ram_if.master  oram,
    input  logic [7:0]  mrom_data,
    input  logic [7:0]  srom_data,
    output logic [1:0]  mbank,
    output logic [1:0]  sbank,
    output logic        latch0,
    output logic        latch1,
    output logic [7:0]  mdin,
    output logic [7:0]  sdin
);

    logic              bsel;     // 1 when the sub owns the bus.
    logic [BUS_AW-1:0] baddr;    // owner byte address.
    logic [7:0]        bdout;    // owner write data.
    logic              brnw;     // owner read flag.
    logic              bwr;      // owner write strobe.
    logic              scr0_cs;
    logic              scr1_cs;
    logic              oram_cs;
    logic              mbank_cs;
    logic              sbank_cs;
    logic [1:0]        lane;     // byte lane from address bit 0.
    logic [7:0]        bdin;     // byte read back from the rams.

    // byte of a ram word picked by address bit 0.
    function automatic logic [7:0] pick_byte(input logic [15:0] w, input logic hi);
        return hi ? w[15:8] : w[7:0];
    endfunction

    //////////////////////////////
    // ownership
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            bsel <= 1'b0; // main first.
        end else if (cen_main) begin
            bsel <= 1'b1; // main slot done so hand over.
        end else if (cen_sub) begin
            bsel <= 1'b0; // back to main.
        end
    end

    // owner mux.
    always_comb begin
        if (bsel) begin
            baddr    = sub_cpu.addr.raw[BUS_AW-1:0];
            bdout    = sub_cpu.dout;
            brnw     = sub_cpu.rnw;
            scr0_cs  = sub_cpu.scr0_cs;
            scr1_cs  = sub_cpu.scr1_cs;
            oram_cs  = sub_cpu.oram_cs;
            mbank_cs = sub_cpu.mbank_cs;
            sbank_cs = sub_cpu.sbank_cs;
            latch0   = sub_cpu.latch0_cs;
            latch1   = sub_cpu.latch1_cs;
        end else begin
            baddr    = main_cpu.addr.raw[BUS_AW-1:0];
            bdout    = main_cpu.dout;
            brnw     = main_cpu.rnw;
            scr0_cs  = main_cpu.scr0_cs;
            scr1_cs  = main_cpu.scr1_cs;
            oram_cs  = main_cpu.oram_cs;
            mbank_cs = main_cpu.mbank_cs;
            sbank_cs = main_cpu.sbank_cs;
            latch0   = main_cpu.latch0_cs;
            latch1   = main_cpu.latch1_cs;
        end
    end

    //////////////////////////////
    // ram ports
    //////////////////////////////

    assign bwr  = ~brnw;
    assign lane = {baddr[0], ~baddr[0]}; // odd address hits the high byte.

    assign scr0.addr  = baddr[BUS_AW-1:1];
    assign scr0.wdata = bdout;
    assign scr0.we    = {2{scr0_cs & bwr}} & lane;
    assign scr1.addr  = baddr[BUS_AW-1:1];
    assign scr1.wdata = bdout;
    assign scr1.we    = {2{scr1_cs & bwr}} & lane;
    assign oram.addr  = baddr[BUS_AW-1:1];
    assign oram.wdata = bdout;
    assign oram.we    = {2{oram_cs & bwr}} & lane;

    always_comb begin
        if (scr0_cs) begin
            bdin = pick_byte(scr0.rdata, baddr[0]);
        end else if (scr1_cs) begin
            bdin = pick_byte(scr1.rdata, baddr[0]);
        end else if (oram_cs) begin
            bdin = pick_byte(oram.rdata, baddr[0]);
        end else begin
            bdin = 8'h00; // bank and latch read as zero.
        end
    end

    //////////////////////////////
    // bank registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            mbank <= 2'd0;
            sbank <= 2'd0;
        end else begin
            if (mbank_cs && bwr) mbank <= bdout[1:0]; // either cpu may write.
            if (sbank_cs && bwr) sbank <= bdout[1:0];
        end
    end

    // read data held outside the owner slot.
    always_ff @(posedge clk) begin
        if (rst) begin
            mdin <= 8'h00;
            sdin <= 8'h00;
        end else if (!bsel) begin
            mdin <= main_cpu.rom_cs ? mrom_data : bdin;
        end else begin
            sdin <= sub_cpu.rom_cs ? srom_data : bdin;
        end
    end

endmodule

// ==== logic/shared_word_ram.sv ====
module shared_word_ram import rthunder_pkg::*; #(
    parameter int WORDS = RAM_WORDS // depth in 16-bit words.
) (
    input  logic       clk,
    word_ram_if.slave  mem
);

    logic [15:0] mem_arr [WORDS]; // no reset on storage.

    //////////////////////////////
    // byte lane writes
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (mem.we[0]) begin
            mem_arr[mem.addr][7:0] <= mem.wdata; // even byte address.
        end
        if (mem.we[1]) begin
            mem_arr[mem.addr][15:8] <= mem.wdata; // odd byte address.
        end
    end

    //////////////////////////////
    // async read
    //////////////////////////////

    // whole word out. the arbiter picks the lane.
    assign mem.rdata = mem_arr[mem.addr];

endmodule

// ==== sources.f ====
logic/rthunder_pkg.sv
logic/rthunder_bus_if.sv
logic/cpu_addr_decoder.sv
logic/shared_bus_arbiter.sv
logic/shared_word_ram.sv
logic/cpu_slot_timer.sv
logic/rthunder_shared_bus.sv
verification/rthunder_shared_bus_assertions.sv
verification/rthunder_shared_bus_tb.sv

// ==== verification/rthunder_shared_bus_assertions.sv ====
module rthunder_shared_bus_assertions (
    input logic clk,
    input logic rst,
    input logic cen_main,
    input logic cen_sub,
    input logic latch0,
    input logic latch1
);

    int fail_count = 0; // failed assertion count.

    // one slot owner per cycle.
    enables_exclusive: assert property (@(posedge clk) disable iff (rst) !(cen_main && cen_sub))
        else begin
            fail_count++;
            $error("cen_main and cen_sub high in the same cycle");
        end

    // owner latch selects are decoded from one bit.
    latches_exclusive: assert property (@(posedge clk) disable iff (rst) !(latch0 && latch1))
        else begin
            fail_count++;
            $error("latch0 and latch1 high in the same cycle");
        end

    // timer comes out of reset silent.
    enables_low_after_reset: assert property (@(posedge clk) rst |=> !cen_main && !cen_sub)
        else begin
            fail_count++;
            $error("slot enable high in the first cycle after reset");
        end

endmodule

bind rthunder_shared_bus rthunder_shared_bus_assertions bus_assertions_inst (
    .clk      (clk),
    .rst      (rst),
    .cen_main (cen_main),
    .cen_sub  (cen_sub),
    .latch0   (latch0),
    .latch1   (latch1)
);

// ==== verification/rthunder_shared_bus_tb.sv ====
module rthunder_shared_bus_tb import rthunder_pkg::*; ();

    localparam int DIV     = 4;               // slot length in cycles.
    localparam int N_DIR   = 9;               // directed accesses per cpu.
    localparam int N_STEPS = N_DIR + 100;     // plus random accesses per cpu.

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        logic        rnw;
        logic        vma;
    } access_t;

    localparam access_t idle_access = '{addr: 16'h0, data: 8'h0, rnw: 1'b1, vma: 1'b0};

    logic        clk;
    logic        rst = 1'b1;
    logic [15:0] maddr, saddr;
    logic [7:0]  mdout, sdout, mrom_data, srom_data;
    logic        mrnw, srnw, mvma, svma;
    logic        cen_main, cen_sub, latch0, latch1;
    logic [1:0]  mbank, sbank;
    logic [7:0]  mdin, sdin;

    //////////////////////////////
    // reference model state
    //////////////////////////////

    logic [15:0] ram_ref [16384];     // scr0, scr1 and oram words back to back.
    bit   [1:0]  ram_set [16384];     // lanes written so far.
    logic [1:0]  mbank_ref = 2'd0;
    logic [1:0]  sbank_ref = 2'd0;
    logic [31:0] rng = 32'd44;        // xorshift state.
    access_t     cur_main, cur_sub;   // access on each cpu bus.
    access_t     dir_tab [2][N_DIR];  // directed accesses. row 0 main, row 1 sub.

    rthunder_shared_bus #(.DIV(DIV), .WORDS(RAM_WORDS)) rthunder_shared_bus_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [13:0] ram_index(input logic [15:0] a);
        return {a[14:13], a[12:1]}; // region then word address.
    endfunction

    // each cpu has its own rom. contents are a fixed mix of the address.
    function automatic logic [7:0] rom_byte(input logic [15:0] a, input logic sub);
        return a[7:0] ^ a[15:8] ^ (sub ? 8'h3c : 8'hc3);
    endfunction

    function automatic access_t make_access(input logic [15:0] a, input logic [7:0] d,
                                            input logic rnw);
        return '{addr: a, data: d, rnw: rnw, vma: 1'b1};
    endfunction

    // expected read byte by region.
    function automatic logic [7:0] expect_read(input access_t a, input logic sub);
        logic [15:0] w;
        if (!a.vma) return 8'h00;                           // no select, no data.
        if (a.addr[15:13] >= reg_rom) return rom_byte(a.addr, sub);
        if (a.addr[15:13] >= reg_bank) return 8'h00;        // bank and latch.
        w = ram_ref[ram_index(a.addr)];
        return a.addr[0] ? w[15:8] : w[7:0];                // odd is high lane.
    endfunction

    function automatic void apply_write(input access_t a);
        if (!a.vma || a.rnw) return;
        if (a.addr[15:13] < reg_bank) begin
            if (a.addr[0]) ram_ref[ram_index(a.addr)][15:8] = a.data;
            else ram_ref[ram_index(a.addr)][7:0] = a.data;
            ram_set[ram_index(a.addr)][a.addr[0]] = 1'b1;
        end else if (a.addr[15:13] == reg_bank) begin
            if (a.addr[12]) sbank_ref = a.data[1:0];
            else mbank_ref = a.data[1:0];
        end
    endfunction

    function automatic access_t random_access();
        access_t a;
        rng    = xorshift32(rng);
        a.addr = rng[31:16];
        a.data = rng[15:8];
        a.rnw  = rng[0];
        a.vma  = rng[1] | rng[2];         // mostly valid.
        if (a.addr[15:13] < reg_bank) begin
            a.addr[12:5] = 8'h00;         // small pool so reads hit earlier writes.
            if (!ram_set[ram_index(a.addr)][a.addr[0]]) a.rnw = 1'b0; // never read x.
        end
        return a;
    endfunction

    task automatic drive_cpu(input logic sub, input access_t a);
        if (sub) begin
            saddr     = a.addr;
            sdout     = a.data;
            srnw      = a.rnw;
            svma      = a.vma;
            srom_data = rom_byte(a.addr, 1'b1);
            cur_sub   = a;
        end else begin
            maddr     = a.addr;
            mdout     = a.data;
            mrnw      = a.rnw;
            mvma      = a.vma;
            mrom_data = rom_byte(a.addr, 1'b0);
            cur_main  = a;
        end
    endtask

    task automatic wait_pulse(input logic sub);
        do @(negedge clk); while (sub ? !cen_sub : !cen_main);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            abort_run("value check failed");
        end
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    initial begin
        drive_cpu(1'b0, idle_access);
        drive_cpu(1'b1, idle_access);
        dir_tab[0][0] = make_access(16'h0000, 8'ha1, 1'b0); // scr0 low lane.
        dir_tab[1][0] = make_access(16'h7000, 8'h02, 1'b0); // sub bank.
        dir_tab[0][1] = make_access(16'h2000, 8'hb2, 1'b0); // scr1 low lane.
        dir_tab[1][1] = make_access(16'h0000, 8'h00, 1'b1);
        dir_tab[0][2] = make_access(16'h5fff, 8'hc3, 1'b0); // oram high lane.
        dir_tab[1][2] = make_access(16'h2000, 8'h00, 1'b1);
        dir_tab[0][3] = make_access(16'h6000, 8'h07, 1'b0); // main bank keeps bits 1..0.
        dir_tab[1][3] = make_access(16'h5fff, 8'h00, 1'b1);
        dir_tab[0][4] = make_access(16'ha123, 8'h00, 1'b1); // rom.
        dir_tab[1][4] = make_access(16'hc456, 8'h00, 1'b1);
        dir_tab[0][5] = make_access(16'h6000, 8'h00, 1'b1); // bank reads zero.
        dir_tab[1][5] = make_access(16'h9000, 8'h00, 1'b1); // latch1.
        dir_tab[0][6] = make_access(16'h8000, 8'h00, 1'b1); // latch0.
        dir_tab[1][6] = make_access(16'h7000, 8'h00, 1'b1);
        dir_tab[0][7] = make_access(16'h0001, 8'hd4, 1'b0); // high lane of word 0.
        dir_tab[1][7] = make_access(16'h0001, 8'h00, 1'b1);
        dir_tab[0][8] = make_access(16'h0001, 8'h00, 1'b1);
        dir_tab[1][8] = make_access(16'h0000, 8'h00, 1'b1); // low lane of word 0 untouched.
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < N_STEPS; i++) begin
            for (int c = 0; c < 2; c++) begin
                wait_pulse(c[0]);
                @(negedge clk);                   // other cpu owns the bus now.
                if (i < N_DIR) drive_cpu(c[0], dir_tab[c][i]);
                else drive_cpu(c[0], random_access());
            end
        end
        wait_pulse(1'b0);                         // last main access checked.
        wait_pulse(1'b1);                         // last sub access checked.
        @(negedge clk);
        if (rthunder_shared_bus_inst.bus_assertions_inst.fail_count == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            abort_run("a bound assertion on the DUT failed");
        end
    end

    //////////////////////////////
    // compare
    //////////////////////////////

    initial begin
        access_t a;
        logic    sub;
        logic    next_sub;
        int      gap;
        next_sub = 1'b0;                          // main pulses first.
        gap      = 0;
        wait (rst == 1'b0);
        check("mbank", mbank, 2'd0);
        check("sbank", sbank, 2'd0);
        check("mdin", mdin, 8'h00);
        check("sdin", sdin, 8'h00);
        forever begin
            @(negedge clk);
            gap++;
            if (rthunder_shared_bus_inst.bus_assertions_inst.fail_count != 0) begin
                abort_run("a bound assertion on the DUT failed");
            end
            if (cen_main || cen_sub) begin
                sub = cen_sub;
                a   = sub ? cur_sub : cur_main;   // access of the slot now ending.
                check("cen_sub", cen_sub, next_sub);
                check("cen spacing", gap, DIV);
                if (a.rnw) begin
                    check(sub ? "sdin" : "mdin", sub ? sdin : mdin, expect_read(a, sub));
                end
                apply_write(a);
                check("mbank", mbank, mbank_ref);
                check("sbank", sbank, sbank_ref);
                check("latch0", latch0, a.vma && a.addr[15:13] == reg_latch && !a.addr[12]);
                check("latch1", latch1, a.vma && a.addr[15:13] == reg_latch && a.addr[12]);
                next_sub = ~next_sub;
                gap      = 0;
            end
        end
    end

    // two cpus, 2 * DIV cycles per access, plus slack.
    initial begin
        #(2 * N_STEPS * 2 * DIV * 10 + 500);
        abort_run("watchdog expired before all accesses were checked");
    end

endmodule
